/* common/mips_defines.svh */
/* global widths, memory depths and the nop word of the mips pipeline
   include in every file that sizes a bus or a memory */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// datapath width, registers and memories alike
`define MIPS_XLEN    32

// word address bits, so each memory holds 2**N words
`define MIPS_IMEM_AW 6
`define MIPS_DMEM_AW 6

// sll r0,r0,0 which writes nothing
`define MIPS_NOP     32'h0000_0000

`endif

/* common/mips_isa_pkg.sv */
/* instruction set types of the integer subset
   import into any file that handles words, register numbers or opcodes */
`include "mips_defines.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;     // data or instruction word
    typedef logic [4:0]            reg_addr_t; // register number
    typedef logic [15:0]           imm_t;      // raw i-type immediate

    // major opcode, bits 31:26
    typedef enum logic [5:0]
    {
        R_TYPE = 6'h00,
        BEQ    = 6'h04,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcode_e;

    // r-type function field, bits 5:0
    typedef enum logic [5:0]
    {
        ADD = 6'h20,
        SUB = 6'h22,
        AND = 6'h24,
        OR  = 6'h25,
        SLT = 6'h2a
    } funct_e;

endpackage

/* common/mips_pipe_pkg.sv */
/* pipeline internal types, alu operations, handshake states and the
   one-bit control flags that travel down the stages */
package mips_pipe_pkg;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // four-phase req/ack state, shared by the loader and the debug port
    typedef enum logic [1:0]
    {
        IDLE,
        SERVE,
        WAIT_DROP
    } hs_state_e;

    typedef logic alu_src_t;    // operand b is the immediate
    typedef logic mem_rd_t;     // load from data memory
    typedef logic mem_wr_t;     // store to data memory
    typedef logic reg_wr_t;     // result goes to the register file
    typedef logic mem_to_reg_t; // writeback takes the load data

endpackage

/* fetch/fetch_unit.sv */
`timescale 1ns/100ps
/* fetch stage, pc register and instruction memory
   the memory is filled through a four-phase req/ack loader while run is low */
`include "mips_defines.svh"

module fetch_unit import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic  SYS_clk,
    input  logic  SYS_reset,
    input  logic  run,
    input  logic  stall,
    input  logic  branch_taken,
    input  word_t branch_target,
    input  logic  imem_req,
    input  word_t imem_addr,        // byte address, low two bits ignored
    input  word_t imem_data,
    output logic  imem_ack,
    output word_t if_instr,
    output word_t if_pc
);
    word_t     imem [2**`MIPS_IMEM_AW];
    word_t     pc;
    hs_state_e load_state;
    logic      load_wr;

    assign load_wr  = (load_state == IDLE) && imem_req;  // one write per transaction
    assign imem_ack = (load_state != IDLE);

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            load_state <= IDLE;
        else
        begin
            case (load_state)
                IDLE:
                    if (imem_req)
                        load_state <= SERVE;
                SERVE:
                    load_state <= imem_req ? WAIT_DROP : IDLE;
                default:
                    if (!imem_req)
                        load_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (load_wr)
            imem[imem_addr[`MIPS_IMEM_AW+1:2]] <= imem_data;
    end

    // stopped core sits at the reset vector
    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || !run)
            pc <= '0;
        else if (!stall)
            pc <= branch_taken ? branch_target : pc + 32'd4;
    end

    assign if_instr = run ? imem[pc[`MIPS_IMEM_AW+1:2]] : `MIPS_NOP;
    assign if_pc    = pc;

    assert property (@(posedge SYS_clk) disable iff (SYS_reset) !(run && imem_req))
        else $error("program load requested while the core is running");

    assert property (@(posedge SYS_clk) disable iff (SYS_reset) $rose(imem_ack) |-> $past(imem_req))
        else $error("imem_ack rose without a pending imem_req");

endmodule

/* decode/register_file.sv */
`timescale 1ns/100ps
/* 32 x 32 register file with write-through to the decode reads
   and a third read port served by a four-phase debug handshake */
module register_file import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  logic      wb_en,
    input  reg_addr_t wb_addr,
    input  word_t     wb_data,
    input  logic      dbg_req,
    input  reg_addr_t dbg_addr,
    output word_t     rs_val,
    output word_t     rt_val,
    output logic      dbg_ack,
    output word_t     dbg_data
);
    word_t     regs [32];
    hs_state_e dbg_state;

    // writeback result is visible in the same cycle
    function automatic word_t read_port(input reg_addr_t addr);
        if (wb_en && wb_addr == addr && addr != '0)
            return wb_data;
        return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_en && wb_addr != '0)    // r0 stays zero
            regs[wb_addr] <= wb_data;
    end

    always_comb
    begin
        rs_val = read_port(rs_addr);
        rt_val = read_port(rt_addr);
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            dbg_state <= IDLE;
        else
        begin
            case (dbg_state)
                IDLE:
                    if (dbg_req)
                        dbg_state <= SERVE;
                SERVE:
                    dbg_state <= dbg_req ? WAIT_DROP : IDLE;
                default:
                    if (!dbg_req)
                        dbg_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (dbg_state == IDLE && dbg_req)
            dbg_data <= read_port(dbg_addr);   // snapshot at the serving edge
    end

    assign dbg_ack = (dbg_state != IDLE);

    assert property (@(posedge SYS_clk) disable iff (SYS_reset) $fell(dbg_ack) |-> $past(!dbg_req))
        else $error("dbg_ack dropped while dbg_req was still high");

endmodule

/* decode/decode_stage.sv */
`timescale 1ns/100ps
/* decode stage, if/id register, main control, sign extension,
   beq resolution with one delay slot and the load/use interlock */
`include "mips_defines.svh"

module decode_stage import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic        SYS_clk,
    input  logic        SYS_reset,
    input  word_t       if_instr,
    input  word_t       if_pc,
    input  reg_addr_t   ex_dest,
    input  reg_wr_t     ex_reg_wr,
    input  reg_addr_t   mem_dest,
    input  reg_wr_t     mem_reg_wr,
    input  reg_wr_t     wb_en,
    input  reg_addr_t   wb_addr,
    input  word_t       wb_data,
    input  logic        dbg_req,
    input  reg_addr_t   dbg_addr,
    output logic        stall,
    output logic        branch_taken,
    output word_t       branch_target,
    output word_t       id_rs_val,
    output word_t       id_rt_val,
    output word_t       id_imm,
    output reg_addr_t   id_dest,
    output funct_e      id_funct,
    output alu_src_t    id_alu_src,
    output mem_rd_t     id_mem_rd,
    output mem_wr_t     id_mem_wr,
    output reg_wr_t     id_reg_wr,
    output mem_to_reg_t id_mem_to_reg,
    output logic        dbg_ack,
    output word_t       dbg_data
);
    word_t     id_instr;
    word_t     id_pc;
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    imm_t      imm;
    logic      use_rs;
    logic      use_rt;
    logic      writes;
    logic      rs_hazard;
    logic      rt_hazard;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            id_instr <= `MIPS_NOP;
            id_pc    <= '0;
        end
        else if (!stall)
        begin
            id_instr <= if_instr;
            id_pc    <= if_pc;
        end
    end

    assign opcode   = opcode_e'(id_instr[31:26]);
    assign rs       = id_instr[25:21];
    assign rt       = id_instr[20:16];
    assign imm      = id_instr[15:0];
    assign id_funct = funct_e'(id_instr[5:0]);
    assign id_imm   = {{16{imm[15]}}, imm};

    always_comb
    begin
        use_rs        = 1'b1;
        use_rt        = 1'b0;
        writes        = 1'b0;
        id_alu_src    = 1'b0;
        id_mem_rd     = 1'b0;
        id_mem_wr     = 1'b0;
        id_mem_to_reg = 1'b0;
        case (opcode)
            R_TYPE:
            begin
                use_rt = 1'b1;
                writes = 1'b1;
            end
            ADDI:
            begin
                id_alu_src = 1'b1;
                writes     = 1'b1;
            end
            LW:
            begin
                id_alu_src    = 1'b1;
                id_mem_rd     = 1'b1;
                id_mem_to_reg = 1'b1;
                writes        = 1'b1;
            end
            SW:
            begin
                id_alu_src = 1'b1;
                id_mem_wr  = 1'b1;
                use_rt     = 1'b1;
            end
            BEQ:
                use_rt = 1'b1;
            default:
                use_rs = 1'b0;      // unknown opcode acts as a nop
        endcase
    end

    assign id_dest   = (opcode == R_TYPE) ? id_instr[15:11] : rt;
    assign id_reg_wr = writes && (id_dest != '0);   // nop and r0 targets carry no write

    // wait until the producer reaches writeback
    assign rs_hazard = use_rs && (rs != '0) &&
                       ((ex_reg_wr && ex_dest == rs) || (mem_reg_wr && mem_dest == rs));
    assign rt_hazard = use_rt && (rt != '0) &&
                       ((ex_reg_wr && ex_dest == rt) || (mem_reg_wr && mem_dest == rt));
    assign stall     = rs_hazard || rt_hazard;

    assign branch_taken  = (opcode == BEQ) && (id_rs_val == id_rt_val) && !stall;
    assign branch_target = id_pc + 32'd4 + {id_imm[29:0], 2'b00};

    register_file regs
    (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs),
        .rt_addr   (rt),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .dbg_req   (dbg_req),
        .dbg_addr  (dbg_addr),
        .rs_val    (id_rs_val),
        .rt_val    (id_rt_val),
        .dbg_ack   (dbg_ack),
        .dbg_data  (dbg_data)
    );

    // bubbles drain execute and memory within two cycles
    assert property (@(posedge SYS_clk) disable iff (SYS_reset) stall[*2] |=> !stall)
        else $error("decode stalled for more than two cycles in a row");

endmodule

/* execute/execute_stage.sv */
`timescale 1ns/100ps
/* execute stage, id/ex register with bubble insertion on stall,
   alu control and the alu itself */
module execute_stage import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic        SYS_clk,
    input  logic        SYS_reset,
    input  logic        stall,
    input  word_t       id_rs_val,
    input  word_t       id_rt_val,
    input  word_t       id_imm,
    input  reg_addr_t   id_dest,
    input  funct_e      id_funct,
    input  alu_src_t    id_alu_src,
    input  mem_rd_t     id_mem_rd,
    input  mem_wr_t     id_mem_wr,
    input  reg_wr_t     id_reg_wr,
    input  mem_to_reg_t id_mem_to_reg,
    output word_t       ex_alu_result,
    output word_t       ex_store_val,
    output reg_addr_t   ex_dest,
    output reg_wr_t     ex_reg_wr,
    output mem_rd_t     ex_mem_rd,
    output mem_wr_t     ex_mem_wr,
    output mem_to_reg_t ex_mem_to_reg
);
    word_t    rs_q;
    word_t    imm_q;
    funct_e   funct_q;
    alu_src_t alu_src_q;
    alu_op_e  alu_op;
    word_t    operand_b;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)     // stalled decode sends a bubble
        begin
            ex_dest       <= '0;
            ex_reg_wr     <= 1'b0;
            ex_mem_rd     <= 1'b0;
            ex_mem_wr     <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            alu_src_q     <= 1'b0;
        end
        else
        begin
            ex_dest       <= id_dest;
            ex_reg_wr     <= id_reg_wr;
            ex_mem_rd     <= id_mem_rd;
            ex_mem_wr     <= id_mem_wr;
            ex_mem_to_reg <= id_mem_to_reg;
            alu_src_q     <= id_alu_src;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        rs_q         <= id_rs_val;
        ex_store_val <= id_rt_val;
        imm_q        <= id_imm;
        funct_q      <= id_funct;
    end

    always_comb
    begin
        if (alu_src_q)
            alu_op = ALU_ADD;       // addi, lw and sw add the offset
        else
        begin
            case (funct_q)
                SUB:     alu_op = ALU_SUB;
                AND:     alu_op = ALU_AND;
                OR:      alu_op = ALU_OR;
                SLT:     alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign operand_b = alu_src_q ? imm_q : ex_store_val;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: ex_alu_result = rs_q - operand_b;
            ALU_AND: ex_alu_result = rs_q & operand_b;
            ALU_OR:  ex_alu_result = rs_q | operand_b;
            ALU_SLT: ex_alu_result = word_t'($signed(rs_q) < $signed(operand_b));
            default: ex_alu_result = rs_q + operand_b;
        endcase
    end

endmodule

/* hdl/memory_stage.sv */
`timescale 1ns/100ps
/* memory and writeback, ex/mem register, word-addressed data memory,
   mem/wb register and the result select toward the register file */
`include "mips_defines.svh"

module memory_stage import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic        SYS_clk,
    input  logic        SYS_reset,
    input  word_t       ex_alu_result,
    input  word_t       ex_store_val,
    input  reg_addr_t   ex_dest,
    input  reg_wr_t     ex_reg_wr,
    input  mem_rd_t     ex_mem_rd,
    input  mem_wr_t     ex_mem_wr,
    input  mem_to_reg_t ex_mem_to_reg,
    output reg_addr_t   mem_dest,
    output reg_wr_t     mem_reg_wr,
    output reg_wr_t     wb_en,
    output reg_addr_t   wb_addr,
    output word_t       wb_data
);
    word_t                    dmem [2**`MIPS_DMEM_AW];
    word_t                    alu_q;
    word_t                    store_q;
    mem_rd_t                  mem_rd_q;
    mem_wr_t                  mem_wr_q;
    mem_to_reg_t              mem_to_reg_q;
    logic [`MIPS_DMEM_AW-1:0] dmem_idx;
    word_t                    load_word;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_dest     <= '0;
            mem_reg_wr   <= 1'b0;
            mem_rd_q     <= 1'b0;
            mem_wr_q     <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end
        else
        begin
            mem_dest     <= ex_dest;
            mem_reg_wr   <= ex_reg_wr;
            mem_rd_q     <= ex_mem_rd;
            mem_wr_q     <= ex_mem_wr;
            mem_to_reg_q <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        alu_q   <= ex_alu_result;
        store_q <= ex_store_val;
    end

    assign dmem_idx  = alu_q[`MIPS_DMEM_AW+1:2];     // byte offset dropped
    assign load_word = mem_rd_q ? dmem[dmem_idx] : '0;

    always_ff @(posedge SYS_clk)
    begin
        if (mem_wr_q)
            dmem[dmem_idx] <= store_q;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_en   <= 1'b0;
            wb_addr <= '0;
        end
        else
        begin
            wb_en   <= mem_reg_wr;
            wb_addr <= mem_dest;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_data <= mem_to_reg_q ? load_word : alu_q;
    end

endmodule

/* hdl/mips_core.sv */
`timescale 1ns/100ps
/* five-stage mips core, fetch decode execute memory writeback
   programs go in through the imem loader while run is low, registers come out on dbg */
module mips_core import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      SYS_clk,
    input  logic      SYS_reset,
    input  logic      run,
    input  logic      imem_req,
    input  word_t     imem_addr,
    input  word_t     imem_data,
    input  logic      dbg_req,
    input  reg_addr_t dbg_addr,
    output logic      imem_ack,
    output logic      dbg_ack,
    output word_t     dbg_data
);
    word_t       if_instr;
    word_t       if_pc;
    logic        stall;
    logic        branch_taken;
    word_t       branch_target;

    word_t       id_rs_val;
    word_t       id_rt_val;
    word_t       id_imm;
    reg_addr_t   id_dest;
    funct_e      id_funct;
    alu_src_t    id_alu_src;
    mem_rd_t     id_mem_rd;
    mem_wr_t     id_mem_wr;
    reg_wr_t     id_reg_wr;
    mem_to_reg_t id_mem_to_reg;

    word_t       ex_alu_result;
    word_t       ex_store_val;
    reg_addr_t   ex_dest;
    reg_wr_t     ex_reg_wr;
    mem_rd_t     ex_mem_rd;
    mem_wr_t     ex_mem_wr;
    mem_to_reg_t ex_mem_to_reg;

    reg_addr_t   mem_dest;
    reg_wr_t     mem_reg_wr;
    reg_wr_t     wb_en;
    reg_addr_t   wb_addr;
    word_t       wb_data;

    // every stage port carries the same name as its net here
    fetch_unit    fetch   (.*);
    decode_stage  decode  (.*);
    execute_stage execute (.*);
    memory_stage  memory  (.*);

endmodule

/* sim/tb_mips_core.sv */
`timescale 1ns/100ps
/* testbench for mips_core, loads short programs through the imem loader,
   runs each one into its halt loop and reads the registers back over dbg */
`include "mips_defines.svh"

module tb_mips_core
    import mips_isa_pkg::*;
();
    localparam int MAX_PROG_LEN   = 16;     // longest program in words
    localparam int NUM_TESTS      = 5;
    localparam int MAX_READS      = 10;     // debug reads in one test
    // load 2 cycles a word, run 4 cycles a word and 3 cycles a read, plus reset and drain
    localparam int TIMEOUT_CYCLES = NUM_TESTS *
        (MAX_PROG_LEN * 2 + MAX_PROG_LEN * 4 + MAX_READS * 3 + 16) + 200;

    logic      SYS_clk;
    logic      SYS_reset;
    logic      run;
    logic      imem_req;
    word_t     imem_addr;
    word_t     imem_data;
    logic      dbg_req;
    reg_addr_t dbg_addr;
    logic      imem_ack;
    logic      dbg_ack;
    word_t     dbg_data;

    int        seed = 32'h9ce2_ed3a;
    string     test_name;
    int        fail_count;
    int        check_count;
    int        test_count;
    int        test_fails_before;
    int        cycle_count;
    logic      check_en;            // dbg_data is compared at the next edge
    reg_addr_t check_reg;
    word_t     exp_value;
    logic      live;                // emitted code is reached at run time
    word_t     prog [$];
    word_t     model_regs [32];
    word_t     model_mem [2**`MIPS_DMEM_AW];

    mips_core DUT (.*);

    initial
    begin
        SYS_clk = 1'b0;
        forever
            #4 SYS_clk = ~SYS_clk;
    end

    task automatic report_violation(input string what);
        fail_count++;
        $display("protocol error: %s", what);
    endtask

    assert property (@(posedge SYS_clk) check_en |-> dbg_data == exp_value)
        else
        begin
            fail_count++;
            $display("CHECK FAILED: %s r%0d expected %h actual %h", test_name,
                     $sampled(check_reg), $sampled(exp_value), $sampled(dbg_data));
        end

    assert property (@(posedge SYS_clk) $fell(SYS_reset) |-> !imem_ack && !dbg_ack)
        else report_violation("an ack output was high right after reset");

    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
                     $rose(imem_ack) |-> $past(imem_req))
        else report_violation("imem_ack rose while imem_req was low");

    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
                     $fell(imem_ack) |-> $past(!imem_req))
        else report_violation("imem_ack fell before imem_req was dropped");

    assert property (@(posedge SYS_clk) disable iff (SYS_reset) $rose(dbg_ack) |-> dbg_req)
        else report_violation("dbg_ack rose while dbg_req was low");

    assert property (@(posedge SYS_clk) disable iff (SYS_reset)
                     $fell(dbg_ack) |-> $past(!dbg_req))
        else report_violation("dbg_ack fell before dbg_req was dropped");

    // all driving and reading happens 1 ns after the edge
    task automatic tick();
        @(posedge SYS_clk);
        #1;
    endtask

    task automatic apply_reset();
        SYS_reset = 1'b1;
        repeat (4)
            tick();
        SYS_reset = 1'b0;
    endtask

    task automatic load_word(input word_t addr, input word_t data);
        imem_addr = addr;
        imem_data = data;
        imem_req  = 1'b1;
        do
            tick();
        while (!imem_ack);
        imem_req = 1'b0;
        do
            tick();
        while (imem_ack);
    endtask

    task automatic read_reg(input reg_addr_t addr, input word_t expected);
        dbg_addr = addr;
        dbg_req  = 1'b1;
        do
            tick();
        while (!dbg_ack);
        check_reg = addr;
        exp_value = expected;
        check_en  = 1'b1;
        check_count++;
        tick();
        check_en = 1'b0;
        dbg_req  = 1'b0;
        do
            tick();
        while (dbg_ack);
    endtask

    function automatic logic [15:0] rand_imm();
        return 16'($random(seed));
    endfunction

    function automatic word_t sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t r_word(input funct_e f, input reg_addr_t rd, rs, rt);
        return {R_TYPE, rs, rt, rd, 5'd0, f};
    endfunction

    function automatic word_t i_word(input opcode_e op, input reg_addr_t rt, rs,
                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic model_write(input reg_addr_t rd, input word_t value);
        if (live && rd != '0)       // r0 is hardwired
            model_regs[rd] = value;
    endtask

    task automatic rtype_op(input funct_e f, input reg_addr_t rd, rs, rt);
        word_t a;
        word_t b;
        word_t result;
        a = model_regs[rs];
        b = model_regs[rt];
        case (f)
            ADD:     result = a + b;
            SUB:     result = a - b;
            AND:     result = a & b;
            OR:      result = a | b;
            default: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        prog.push_back(r_word(f, rd, rs, rt));
        model_write(rd, result);
    endtask

    task automatic addi_op(input reg_addr_t rt, rs, input logic [15:0] imm);
        prog.push_back(i_word(ADDI, rt, rs, imm));
        model_write(rt, model_regs[rs] + sext(imm));
    endtask

    task automatic sw_op(input reg_addr_t rt, rs, input logic [15:0] imm);
        word_t addr;
        addr = model_regs[rs] + sext(imm);
        prog.push_back(i_word(SW, rt, rs, imm));
        if (live)
            model_mem[addr[`MIPS_DMEM_AW+1:2]] = model_regs[rt];   // word addressed
    endtask

    task automatic lw_op(input reg_addr_t rt, rs, input logic [15:0] imm);
        word_t addr;
        addr = model_regs[rs] + sext(imm);
        prog.push_back(i_word(LW, rt, rs, imm));
        model_write(rt, model_mem[addr[`MIPS_DMEM_AW+1:2]]);
    endtask

    task automatic beq_op(input reg_addr_t rs, rt, input logic [15:0] imm);
        prog.push_back(i_word(BEQ, rt, rs, imm));
    endtask

    // beq r0,r0 back to itself, nop in its delay slot
    task automatic halt_loop();
        prog.push_back(i_word(BEQ, 5'd0, 5'd0, 16'hffff));
        prog.push_back(`MIPS_NOP);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_count++;
        test_fails_before = fail_count;
        prog.delete();
        live = 1'b1;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        apply_reset();
    endtask

    task automatic end_test();
        $display("test %-14s %s", test_name,
                 (fail_count == test_fails_before) ? "ok" : "had failures");
    endtask

    task automatic run_program();
        for (int i = 0; i < prog.size(); i++)
            load_word(32'(i * 4), prog[i]);
        run = 1'b1;
        repeat (prog.size() * 4 + 8)    // worst case two stall cycles each, plus drain
            tick();
    endtask

    task automatic stop_program();
        run = 1'b0;
        repeat (4)
            tick();
    endtask

    task automatic check_regs(input int first, input int last);
        for (int i = first; i <= last; i++)
            read_reg(reg_addr_t'(i), model_regs[i]);
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge SYS_clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, a handshake or a program never finished",
                 cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        SYS_reset   = 1'b1;
        run         = 1'b0;
        imem_req    = 1'b0;
        imem_addr   = '0;
        imem_data   = '0;
        dbg_req     = 1'b0;
        dbg_addr    = '0;
        check_en    = 1'b0;
        check_reg   = '0;
        exp_value   = '0;
        live        = 1'b1;
        fail_count  = 0;
        check_count = 0;
        test_count  = 0;

        start_test("reset_state");
        read_reg(0, 0);
        read_reg(1, 0);
        read_reg(15, 0);
        read_reg(31, 0);
        end_test();

        // each op reads the result of the one before it
        start_test("rtype_chain");
        addi_op(1, 0, rand_imm());
        addi_op(2, 0, rand_imm());
        rtype_op(ADD, 3, 1, 2);
        rtype_op(SUB, 4, 3, 1);
        rtype_op(AND, 5, 4, 3);
        rtype_op(OR, 6, 5, 2);
        rtype_op(SLT, 7, 6, 4);
        rtype_op(SLT, 8, 4, 6);
        halt_loop();
        run_program();
        stop_program();
        check_regs(1, 8);
        end_test();

        start_test("addi_negative");
        addi_op(9, 0, rand_imm() & 16'h7fff);
        addi_op(10, 9, rand_imm() | 16'h8000);
        addi_op(11, 10, 16'hffff);
        addi_op(0, 10, 16'd5);          // write to r0 is dropped
        rtype_op(ADD, 12, 0, 11);
        halt_loop();
        run_program();
        stop_program();
        read_reg(0, 0);
        check_regs(9, 12);
        end_test();

        start_test("store_load");
        addi_op(1, 0, rand_imm());
        addi_op(2, 0, rand_imm());
        sw_op(1, 0, 16'd8);
        sw_op(2, 0, 16'd20);
        lw_op(3, 0, 16'd8);
        lw_op(4, 0, 16'd20);
        rtype_op(ADD, 5, 4, 3);         // uses the load result at once
        rtype_op(SUB, 6, 3, 4);
        halt_loop();
        run_program();
        stop_program();
        check_regs(1, 6);
        end_test();

        start_test("branch_rules");
        addi_op(1, 0, rand_imm());
        addi_op(2, 1, 16'd0);
        beq_op(1, 2, 16'd3);            // taken and lands past the two skipped words
        addi_op(3, 0, rand_imm());      // delay slot
        live = 1'b0;
        addi_op(4, 0, rand_imm());
        addi_op(5, 0, rand_imm());
        live = 1'b1;
        addi_op(6, 1, 16'd1);
        beq_op(1, 6, 16'd2);            // unequal so r8 still runs, taken would skip it
        addi_op(7, 0, rand_imm());
        addi_op(8, 0, rand_imm());
        halt_loop();
        run_program();
        read_reg(3, model_regs[3]);     // served while the core spins in its halt loop
        stop_program();
        check_regs(1, 8);
        end_test();

        $display("%0d tests, %0d checks, %0d failures", test_count, check_count, fail_count);
        if (fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* mips_core.f */
+incdir+common
common/mips_isa_pkg.sv
common/mips_pipe_pkg.sv
fetch/fetch_unit.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_core.sv
sim/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - include_dirs:
      - common
    files:
      - common/mips_isa_pkg.sv
      - common/mips_pipe_pkg.sv
      - fetch/fetch_unit.sv
      - decode/register_file.sv
      - decode/decode_stage.sv
      - execute/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/mips_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_mips_core.sv
